// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_serv_top -f build.f -o tb_serv_top
	./obj_dir/tb_serv_top

clean:
	rm -rf obj_dir

// ==== build.f ====
hdl/serv_pkg.sv
hdl/serv_state.sv
hdl/serv_decode.sv
hdl/serv_immdec.sv
hdl/serv_alu.sv
hdl/serv_ctrl.sv
hdl/serv_rf_if.sv
hdl/serv_top.sv
testbench/serv_asserts.sv
testbench/tb_serv_top.sv

// ==== hdl/serv_alu.sv ====
`timescale 1ns/100ps

module serv_alu (
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_cnt_en,
   input  serv_pkg::cnt_t    i_cnt,
   input  serv_pkg::alu_op_e i_alu_op,
   input  logic              i_op_b_imm,
   input  logic              i_rs1,
   input  logic              i_rs2,
   input  logic              i_imm,
   output logic              o_rd
);
   import serv_pkg::*;

   logic op_b;
   logic sub;
   logic b_in;
   logic carry_in;
   logic carry_r;
   logic sum;

   assign op_b = i_op_b_imm ? i_imm : i_rs2;
   assign sub  = (i_alu_op == ALU_SUB);

   // Two's complement subtract as inverted b plus one
   assign b_in     = op_b ^ sub;
   assign carry_in = (i_cnt == '0) ? sub : carry_r;
   assign sum      = i_rs1 ^ b_in ^ carry_in;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_r <= 1'b0;
      end else if (i_cnt_en) begin
         carry_r <= (i_rs1 & b_in) | (i_rs1 & carry_in) | (b_in & carry_in);
      end
   end

   always_comb begin
      case (i_alu_op)
         ALU_XOR: o_rd = i_rs1 ^ op_b;
         ALU_OR:  o_rd = i_rs1 | op_b;
         ALU_AND: o_rd = i_rs1 & op_b;
         default: o_rd = sum;
      endcase
   end

endmodule

// ==== hdl/serv_ctrl.sv ====
`timescale 1ns/100ps

module serv_ctrl #(
   parameter serv_pkg::word_t RESET_PC = 32'h0
) (
   input  logic            clk,
   input  logic            i_rst_n,
   input  logic            i_cnt_en,
   input  serv_pkg::cnt_t  i_cnt,
   input  logic            i_cnt_done,
   input  logic            i_pc_rel,
   input  logic            i_imm,
   output serv_pkg::word_t o_ibus_adr,
   output logic            o_rd
);
   import serv_pkg::*;

   word_t pc;
   word_t npc_r;
   logic  pc_bit;
   logic  four_bit;
   logic  pc4_cin;
   logic  pc4_sum;
   logic  pc4_carry;
   logic  rel_a;
   logic  rel_cin;
   logic  rel_carry;

   assign pc_bit = pc[i_cnt];

   // PC plus 4
   assign four_bit = (i_cnt == cnt_t'(2));
   assign pc4_cin  = (i_cnt == '0) ? 1'b0 : pc4_carry;
   assign pc4_sum  = pc_bit ^ four_bit ^ pc4_cin;

   // PC or zero plus the U-type immediate
   assign rel_a   = i_pc_rel & pc_bit;
   assign rel_cin = (i_cnt == '0) ? 1'b0 : rel_carry;
   assign o_rd    = rel_a ^ i_imm ^ rel_cin;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc        <= RESET_PC;
         pc4_carry <= 1'b0;
         rel_carry <= 1'b0;
      end else begin
         if (i_cnt_en) begin
            pc4_carry <= (pc_bit & four_bit) | (pc_bit & pc4_cin) | (four_bit & pc4_cin);
            rel_carry <= (rel_a & i_imm) | (rel_a & rel_cin) | (i_imm & rel_cin);
         end
         // Top bit is still on the adder output in the last count
         if (i_cnt_done) begin
            pc <= {pc4_sum, npc_r[XLEN-1:1]};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         npc_r <= {pc4_sum, npc_r[XLEN-1:1]};
      end
   end

   assign o_ibus_adr = pc;

endmodule

// ==== hdl/serv_decode.sv ====
`timescale 1ns/100ps

module serv_decode (
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_fetch_done,
   input  serv_pkg::word_t   i_ibus_rdt,
   output serv_pkg::alu_op_e o_alu_op,
   output logic              o_op_b_imm,
   output logic              o_rd_from_ctrl,
   output logic              o_pc_rel,
   output logic              o_rd_op
);
   import serv_pkg::*;

   opcode_e    opcode;
   opcode_e    opcode_d;
   logic [2:0] funct3;
   logic       funct7_5;
   logic       funct3_ok;

   always_comb begin
      case (i_ibus_rdt[6:0])
         OPC_OP:     opcode_d = OPC_OP;
         OPC_OP_IMM: opcode_d = OPC_OP_IMM;
         OPC_LUI:    opcode_d = OPC_LUI;
         OPC_AUIPC:  opcode_d = OPC_AUIPC;
         default:    opcode_d = OPC_OTHER;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         opcode <= OPC_OTHER;
      end else if (i_fetch_done) begin
         opcode <= opcode_d;
      end
   end

   always_ff @(posedge clk) begin
      if (i_fetch_done) begin
         funct3   <= i_ibus_rdt[14:12];
         funct7_5 <= i_ibus_rdt[30];
      end
   end

   always_comb begin
      case (funct3)
         3'b000:  o_alu_op = (opcode == OPC_OP && funct7_5) ? ALU_SUB : ALU_ADD;
         3'b100:  o_alu_op = ALU_XOR;
         3'b110:  o_alu_op = ALU_OR;
         3'b111:  o_alu_op = ALU_AND;
         default: o_alu_op = ALU_ADD;
      endcase
   end

   // Shifts and compares share these opcodes but are not executed
   assign funct3_ok = (funct3 == 3'b000) | (funct3 == 3'b100) |
                      (funct3 == 3'b110) | (funct3 == 3'b111);

   assign o_op_b_imm     = (opcode == OPC_OP_IMM);
   assign o_rd_from_ctrl = (opcode == OPC_LUI) | (opcode == OPC_AUIPC);
   assign o_pc_rel       = (opcode == OPC_AUIPC);
   assign o_rd_op        = (((opcode == OPC_OP) | (opcode == OPC_OP_IMM)) & funct3_ok) |
                           o_rd_from_ctrl;

endmodule

// ==== hdl/serv_immdec.sv ====
`timescale 1ns/100ps

module serv_immdec (
   input  logic                clk,
   input  logic                i_rst_n,
   input  logic                i_fetch_done,
   input  logic                i_cnt_en,
   input  serv_pkg::word_t     i_ibus_rdt,
   output logic                o_imm,
   output serv_pkg::reg_addr_t o_rd_addr,
   output serv_pkg::reg_addr_t o_rs1_addr,
   output serv_pkg::reg_addr_t o_rs2_addr
);
   import serv_pkg::*;

   word_t imm_r;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_rd_addr  <= '0;
         o_rs1_addr <= '0;
         o_rs2_addr <= '0;
      end else if (i_fetch_done) begin
         o_rd_addr  <= i_ibus_rdt[11:7];
         o_rs1_addr <= i_ibus_rdt[19:15];
         o_rs2_addr <= i_ibus_rdt[24:20];
      end
   end

   // Opcode bit 2 is set only for LUI and AUIPC
   always_ff @(posedge clk) begin
      if (i_fetch_done) begin
         if (i_ibus_rdt[2]) begin
            imm_r <= {i_ibus_rdt[31:12], 12'b0};
         end else begin
            imm_r <= {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:20]};
         end
      end else if (i_cnt_en) begin
         // Sign bit stays in place while the rest moves down
         imm_r <= {imm_r[XLEN-1], imm_r[XLEN-1:1]};
      end
   end

   assign o_imm = imm_r[0];

endmodule

// ==== hdl/serv_pkg.sv ====
package serv_pkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;
   localparam int CNT_W      = 5;

   typedef logic [XLEN-1:0]       word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [CNT_W-1:0]      cnt_t;

   // Major opcodes that the core executes
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_AUIPC  = 7'b0010111,
      OPC_OTHER  = 7'b0000000
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_XOR,
      ALU_OR,
      ALU_AND
   } alu_op_e;

   typedef enum logic [1:0] {
      ST_FETCH,
      ST_RF_REQ,
      ST_RF_WAIT,
      ST_RUN
   } state_e;

endpackage

// ==== hdl/serv_rf_if.sv ====
`timescale 1ns/100ps

module serv_rf_if (
   input  logic                i_cnt_en,
   input  logic                i_rd_op,
   input  logic                i_rd_from_ctrl,
   input  logic                i_alu_rd,
   input  logic                i_ctrl_rd,
   input  serv_pkg::reg_addr_t i_rd_addr,
   input  serv_pkg::reg_addr_t i_rs1_addr,
   input  serv_pkg::reg_addr_t i_rs2_addr,
   output serv_pkg::reg_addr_t o_rreg0,
   output serv_pkg::reg_addr_t o_rreg1,
   output serv_pkg::reg_addr_t o_wreg0,
   output logic                o_wen0,
   output logic                o_wdata0
);

   assign o_rreg0 = i_rs1_addr;
   assign o_rreg1 = i_rs2_addr;
   assign o_wreg0 = i_rd_addr;

   // x0 stays zero
   assign o_wen0 = i_cnt_en & i_rd_op & (|i_rd_addr);

   assign o_wdata0 = i_rd_from_ctrl ? i_ctrl_rd : i_alu_rd;

endmodule

// ==== hdl/serv_state.sv ====
`timescale 1ns/100ps

module serv_state (
   input  logic           clk,
   input  logic           i_rst_n,
   input  logic           i_ibus_ack,
   input  logic           i_rf_ready,
   output logic           o_ibus_cyc,
   output logic           o_rf_rreq,
   output logic           o_fetch_done,
   output logic           o_cnt_en,
   output logic           o_cnt_done,
   output serv_pkg::cnt_t o_cnt
);
   import serv_pkg::*;

   state_e state;
   state_e state_nxt;
   cnt_t   cnt;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_FETCH: begin
            if (i_ibus_ack) begin
               state_nxt = ST_RF_REQ;
            end
         end
         // Ready may already come back in the request cycle
         ST_RF_REQ: begin
            state_nxt = i_rf_ready ? ST_RUN : ST_RF_WAIT;
         end
         ST_RF_WAIT: begin
            if (i_rf_ready) begin
               state_nxt = ST_RUN;
            end
         end
         ST_RUN: begin
            if (o_cnt_done) begin
               state_nxt = ST_FETCH;
            end
         end
         default: state_nxt = ST_FETCH;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= ST_FETCH;
         cnt   <= '0;
      end else begin
         state <= state_nxt;
         // Wraps back to zero after bit 31
         if (o_cnt_en) begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   assign o_ibus_cyc   = (state == ST_FETCH);
   assign o_fetch_done = o_ibus_cyc & i_ibus_ack;
   assign o_rf_rreq    = (state == ST_RF_REQ);
   assign o_cnt_en     = (state == ST_RUN);
   assign o_cnt_done   = o_cnt_en & (cnt == '1);
   assign o_cnt        = cnt;

endmodule

// ==== hdl/serv_top.sv ====
`timescale 1ns/100ps

module serv_top #(
   parameter serv_pkg::word_t RESET_PC = 32'h0
) (
   input  logic                clk,
   input  logic                i_rst_n,
   // Instruction bus
   output serv_pkg::word_t     o_ibus_adr,
   output logic                o_ibus_cyc,
   input  serv_pkg::word_t     i_ibus_rdt,
   input  logic                i_ibus_ack,
   // Register file
   output logic                o_rf_rreq,
   input  logic                i_rf_ready,
   output serv_pkg::reg_addr_t o_rreg0,
   output serv_pkg::reg_addr_t o_rreg1,
   input  logic                i_rdata0,
   input  logic                i_rdata1,
   output serv_pkg::reg_addr_t o_wreg0,
   output logic                o_wen0,
   output logic                o_wdata0
);
   import serv_pkg::*;

   logic      fetch_done;
   logic      cnt_en;
   cnt_t      cnt;
   logic      cnt_done;

   alu_op_e   alu_op;
   logic      op_b_imm;
   logic      rd_from_ctrl;
   logic      pc_rel;
   logic      rd_op;

   logic      imm;
   reg_addr_t rd_addr;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;

   logic      alu_rd;
   logic      ctrl_rd;

   serv_state state (
      .clk          (clk       ),
      .i_rst_n      (i_rst_n   ),
      .i_ibus_ack   (i_ibus_ack),
      .i_rf_ready   (i_rf_ready),
      .o_ibus_cyc   (o_ibus_cyc),
      .o_rf_rreq    (o_rf_rreq ),
      .o_fetch_done (fetch_done),
      .o_cnt_en     (cnt_en    ),
      .o_cnt_done   (cnt_done  ),
      .o_cnt        (cnt       )
   );

   serv_decode decode (
      .clk            (clk         ),
      .i_rst_n        (i_rst_n     ),
      .i_fetch_done   (fetch_done  ),
      .i_ibus_rdt     (i_ibus_rdt  ),
      .o_alu_op       (alu_op      ),
      .o_op_b_imm     (op_b_imm    ),
      .o_rd_from_ctrl (rd_from_ctrl),
      .o_pc_rel       (pc_rel      ),
      .o_rd_op        (rd_op       )
   );

   serv_immdec immdec (
      .clk          (clk       ),
      .i_rst_n      (i_rst_n   ),
      .i_fetch_done (fetch_done),
      .i_cnt_en     (cnt_en    ),
      .i_ibus_rdt   (i_ibus_rdt),
      .o_imm        (imm       ),
      .o_rd_addr    (rd_addr   ),
      .o_rs1_addr   (rs1_addr  ),
      .o_rs2_addr   (rs2_addr  )
   );

   serv_alu alu (
      .clk        (clk     ),
      .i_rst_n    (i_rst_n ),
      .i_cnt_en   (cnt_en  ),
      .i_cnt      (cnt     ),
      .i_alu_op   (alu_op  ),
      .i_op_b_imm (op_b_imm),
      .i_rs1      (i_rdata0),
      .i_rs2      (i_rdata1),
      .i_imm      (imm     ),
      .o_rd       (alu_rd  )
   );

   serv_ctrl #(
      .RESET_PC (RESET_PC)
   ) ctrl (
      .clk        (clk       ),
      .i_rst_n    (i_rst_n   ),
      .i_cnt_en   (cnt_en    ),
      .i_cnt      (cnt       ),
      .i_cnt_done (cnt_done  ),
      .i_pc_rel   (pc_rel    ),
      .i_imm      (imm       ),
      .o_ibus_adr (o_ibus_adr),
      .o_rd       (ctrl_rd   )
   );

   serv_rf_if rf_if (
      .i_cnt_en       (cnt_en      ),
      .i_rd_op        (rd_op       ),
      .i_rd_from_ctrl (rd_from_ctrl),
      .i_alu_rd       (alu_rd      ),
      .i_ctrl_rd      (ctrl_rd     ),
      .i_rd_addr      (rd_addr     ),
      .i_rs1_addr     (rs1_addr    ),
      .i_rs2_addr     (rs2_addr    ),
      .o_rreg0        (o_rreg0     ),
      .o_rreg1        (o_rreg1     ),
      .o_wreg0        (o_wreg0     ),
      .o_wen0         (o_wen0      ),
      .o_wdata0       (o_wdata0    )
   );

endmodule

// ==== testbench/serv_asserts.sv ====
`timescale 1ns/100ps

module serv_asserts (
   input logic           clk,
   input logic           i_rst_n,
   input logic           o_ibus_cyc,
   input logic           o_rf_rreq,
   input logic           o_cnt_en,
   input serv_pkg::cnt_t o_cnt
);

   rreq_one_cycle: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_rf_rreq |=> !o_rf_rreq)
      else $error("o_rf_rreq held for more than one cycle");

   // A run starts at count 0, keeps going and stops right after count 31
   run_starts_at_zero: assert property (@(posedge clk) disable iff (!i_rst_n)
      $rose(o_cnt_en) |-> (o_cnt == '0))
      else $error("o_cnt_en rose with a nonzero count");

   run_continues: assert property (@(posedge clk) disable iff (!i_rst_n)
      (o_cnt_en && (o_cnt != '1)) |=> o_cnt_en)
      else $error("o_cnt_en dropped before count 31");

   run_stops: assert property (@(posedge clk) disable iff (!i_rst_n)
      (o_cnt_en && (o_cnt == '1)) |=> !o_cnt_en)
      else $error("o_cnt_en stayed high past count 31");

   // A new fetch opens only as the run closes
   fetch_after_run: assert property (@(posedge clk) disable iff (!i_rst_n)
      $rose(o_ibus_cyc) |-> $fell(o_cnt_en))
      else $error("o_ibus_cyc rose while no run was ending");

endmodule

bind serv_state serv_asserts state_asserts (
   .clk        (clk       ),
   .i_rst_n    (i_rst_n   ),
   .o_ibus_cyc (o_ibus_cyc),
   .o_rf_rreq  (o_rf_rreq ),
   .o_cnt_en   (o_cnt_en  ),
   .o_cnt      (o_cnt     )
);

// ==== testbench/tb_serv_top.sv ====
`timescale 1ns/100ps

module tb_serv_top;
   import serv_pkg::*;

   localparam word_t RESET_PC = 32'h100;
   localparam int    TIMEOUT  = 100;

   logic      clk;
   logic      i_rst_n;
   word_t     o_ibus_adr;
   logic      o_ibus_cyc;
   word_t     i_ibus_rdt;
   logic      i_ibus_ack;
   logic      o_rf_rreq;
   logic      i_rf_ready;
   reg_addr_t o_rreg0;
   reg_addr_t o_rreg1;
   logic      i_rdata0;
   logic      i_rdata1;
   reg_addr_t o_wreg0;
   logic      o_wen0;
   logic      o_wdata0;

   integer seed;
   word_t  exp_pc;
   // rf holds what the core wrote and exp_rf what it should hold
   word_t  rf [32];
   word_t  exp_rf [32];

   serv_top #(
      .RESET_PC (RESET_PC)
   ) uut (
      .clk        (clk       ),
      .i_rst_n    (i_rst_n   ),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_rf_rreq  (o_rf_rreq ),
      .i_rf_ready (i_rf_ready),
      .o_rreg0    (o_rreg0   ),
      .o_rreg1    (o_rreg1   ),
      .i_rdata0   (i_rdata0  ),
      .i_rdata1   (i_rdata1  ),
      .o_wreg0    (o_wreg0   ),
      .o_wen0     (o_wen0    ),
      .o_wdata0   (o_wdata0  )
   );

   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   task automatic stop_on_failure();
      $display("*** FAILED ***");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t act, input word_t exp);
      if (act !== exp) begin
         $display("CHECK FAILED %s: got %h, expected %h", name, act, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_addr(input string name, input reg_addr_t act, input reg_addr_t exp);
      if (act !== exp) begin
         $display("CHECK FAILED %s: got %h, expected %h", name, act, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_bit(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         $display("CHECK FAILED %s: got %h, expected %h", name, act, exp);
         stop_on_failure();
      end
   endtask

   function automatic word_t rtype_word(input logic [6:0] f7, input reg_addr_t rs2,
                                        input reg_addr_t rs1, input logic [2:0] f3,
                                        input reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, OPC_OP};
   endfunction

   function automatic word_t itype_word(input logic [11:0] imm, input reg_addr_t rs1,
                                        input logic [2:0] f3, input reg_addr_t rd);
      return {imm, rs1, f3, rd, OPC_OP_IMM};
   endfunction

   function automatic word_t utype_word(input logic [19:0] imm, input reg_addr_t rd,
                                        input opcode_e opc);
      return {imm, rd, opc};
   endfunction

   // Word-level RV32I reference for the supported instructions
   function automatic logic expected_write(input word_t instr, input word_t pc,
                                           input word_t a, input word_t b,
                                           output word_t value);
      word_t imm_i;
      word_t imm_u;
      logic  keep;
      imm_i = {{20{instr[31]}}, instr[31:20]};
      imm_u = {instr[31:12], 12'h000};
      keep  = 1'b1;
      value = '0;
      case (instr[6:0])
         OPC_OP: begin
            case (instr[14:12])
               3'b000:  value = instr[30] ? a - b : a + b;
               3'b100:  value = a ^ b;
               3'b110:  value = a | b;
               3'b111:  value = a & b;
               default: keep = 1'b0;
            endcase
         end
         OPC_OP_IMM: begin
            case (instr[14:12])
               3'b000:  value = a + imm_i;
               3'b100:  value = a ^ imm_i;
               3'b110:  value = a | imm_i;
               3'b111:  value = a & imm_i;
               default: keep = 1'b0;
            endcase
         end
         OPC_LUI:   value = imm_u;
         OPC_AUIPC: value = pc + imm_u;
         default:   keep = 1'b0;
      endcase
      return keep && (instr[11:7] != 5'd0);
   endfunction

   task automatic load_random_regs();
      for (int i = 1; i < 32; i++) begin
         rf[reg_addr_t'(i)]     = $random(seed);
         exp_rf[reg_addr_t'(i)] = rf[reg_addr_t'(i)];
      end
   endtask

   task automatic compare_rf();
      for (int i = 0; i < 32; i++) begin
         check_word($sformatf("x%0d", i), rf[reg_addr_t'(i)], exp_rf[reg_addr_t'(i)]);
      end
   endtask

   task automatic await_fetch();
      int n;
      n = 0;
      while (!o_ibus_cyc) begin
         if (n == TIMEOUT) begin
            $display("Timeout waiting for an instruction fetch");
            stop_on_failure();
         end
         n++;
         @(negedge clk);
      end
   endtask

   task automatic await_rf_request();
      int n;
      n = 0;
      while (!o_rf_rreq) begin
         if (n == TIMEOUT) begin
            $display("Timeout waiting for a register file read request");
            stop_on_failure();
         end
         n++;
         @(negedge clk);
      end
   endtask

   // One full instruction through fetch, operand request and the serial run
   task automatic execute(input word_t instr, input int ack_dly, input int rdy_dly);
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
      word_t     exp_val;
      logic      exp_wen;
      rs1     = instr[19:15];
      rs2     = instr[24:20];
      rd      = instr[11:7];
      exp_wen = expected_write(instr, exp_pc, exp_rf[rs1], exp_rf[rs2], exp_val);
      await_fetch();
      check_word("o_ibus_adr", o_ibus_adr, exp_pc);
      repeat (ack_dly) begin
         @(negedge clk);
         check_bit("o_ibus_cyc", o_ibus_cyc, 1'b1);
         check_word("o_ibus_adr", o_ibus_adr, exp_pc);
      end
      i_ibus_rdt = instr;
      i_ibus_ack = 1'b1;
      @(negedge clk);
      i_ibus_ack = 1'b0;
      i_ibus_rdt = $random(seed);
      check_bit("o_ibus_cyc", o_ibus_cyc, 1'b0);
      await_rf_request();
      check_addr("o_rreg0", o_rreg0, rs1);
      check_addr("o_rreg1", o_rreg1, rs2);
      repeat (rdy_dly) begin
         @(negedge clk);
         check_bit("o_rf_rreq", o_rf_rreq, 1'b0);
      end
      i_rf_ready = 1'b1;
      @(negedge clk);
      i_rf_ready = 1'b0;
      for (int k = 0; k < 32; k++) begin
         i_rdata0 = rf[rs1][cnt_t'(k)];
         i_rdata1 = rf[rs2][cnt_t'(k)];
         check_bit("o_wen0", o_wen0, exp_wen);
         if (exp_wen) begin
            check_addr("o_wreg0", o_wreg0, rd);
         end
         // Register file takes the bit on the rising edge
         @(posedge clk);
         if (o_wen0) begin
            rf[o_wreg0][cnt_t'(k)] = o_wdata0;
         end
         @(negedge clk);
      end
      check_bit("o_ibus_cyc", o_ibus_cyc, 1'b1);
      if (exp_wen) begin
         exp_rf[rd] = exp_val;
      end
      exp_pc = exp_pc + 32'd4;
      check_word("o_ibus_adr", o_ibus_adr, exp_pc);
      compare_rf();
   endtask

   task automatic test_reset();
      @(negedge clk);
      check_bit("o_wen0", o_wen0, 1'b0);
      check_bit("o_rf_rreq", o_rf_rreq, 1'b0);
      check_bit("o_ibus_cyc", o_ibus_cyc, 1'b1);
      check_word("o_ibus_adr", o_ibus_adr, RESET_PC);
   endtask

   task automatic test_reg_ops();
      for (int pass = 0; pass < 2; pass++) begin
         load_random_regs();
         execute(rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd10), 0, 0);
         execute(rtype_word(7'h20, 5'd4, 5'd3, 3'b000, 5'd11), 0, 0);
         execute(rtype_word(7'h00, 5'd6, 5'd5, 3'b100, 5'd12), 0, 0);
         execute(rtype_word(7'h00, 5'd8, 5'd7, 3'b110, 5'd13), 0, 0);
         execute(rtype_word(7'h00, 5'd9, 5'd1, 3'b111, 5'd1), 0, 0);
         execute(rtype_word(7'h20, 5'd0, 5'd2, 3'b000, 5'd14), 0, 0);
      end
   endtask

   task automatic test_imm_ops();
      load_random_regs();
      execute(itype_word(12'h7ff, 5'd1, 3'b000, 5'd5), 0, 0);
      execute(itype_word(12'h800, 5'd2, 3'b000, 5'd6), 0, 0);
      execute(itype_word(12'hfff, 5'd3, 3'b000, 5'd7), 0, 0);
      execute(itype_word(12'hf0f, 5'd4, 3'b100, 5'd8), 0, 0);
      execute(itype_word(12'h0ff, 5'd4, 3'b100, 5'd9), 0, 0);
      execute(itype_word(12'h800, 5'd5, 3'b110, 5'd10), 0, 0);
      execute(itype_word(12'h123, 5'd6, 3'b110, 5'd11), 0, 0);
      execute(itype_word(12'hfff, 5'd7, 3'b111, 5'd12), 0, 0);
      execute(itype_word(12'h3c5, 5'd8, 3'b111, 5'd13), 0, 0);
   endtask

   task automatic test_upper_imm();
      execute(utype_word(20'hdead5, 5'd14, OPC_LUI), 0, 0);
      execute(utype_word(20'h00001, 5'd15, OPC_LUI), 0, 0);
      execute(utype_word(20'h12345, 5'd16, OPC_AUIPC), 0, 0);
      execute(utype_word(20'hfffff, 5'd17, OPC_AUIPC), 0, 0);
   endtask

   task automatic test_no_write();
      execute(rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd0), 0, 0);
      execute(utype_word(20'habcde, 5'd0, OPC_LUI), 0, 0);
      // Branch opcode with a nonzero rd field
      execute({7'h00, 5'd3, 5'd4, 3'b000, 5'd21, 7'b1100011}, 0, 0);
      // SLT and SLLI are not executed by the core
      execute(rtype_word(7'h00, 5'd3, 5'd4, 3'b010, 5'd20), 0, 0);
      execute(itype_word(12'h004, 5'd4, 3'b001, 5'd22), 0, 0);
   endtask

   task automatic test_random_mix();
      word_t      instr;
      reg_addr_t  rd;
      reg_addr_t  rs1;
      reg_addr_t  rs2;
      logic [2:0] f3;
      int         kind;
      int         ack_dly;
      int         rdy_dly;
      load_random_regs();
      for (int n = 0; n < 24; n++) begin
         rd   = reg_addr_t'($random(seed));
         rs1  = reg_addr_t'($random(seed));
         rs2  = reg_addr_t'($random(seed));
         kind = $unsigned($random(seed)) % 4;
         case (kind)
            0:       f3 = 3'b000;
            1:       f3 = 3'b100;
            2:       f3 = 3'b110;
            default: f3 = 3'b111;
         endcase
         kind = $unsigned($random(seed)) % 5;
         case (kind)
            0:       instr = rtype_word(7'h00, rs2, rs1, f3, rd);
            1:       instr = rtype_word(7'h20, rs2, rs1, 3'b000, rd);
            2:       instr = itype_word(12'($random(seed)), rs1, f3, rd);
            3:       instr = utype_word(20'($random(seed)), rd, OPC_LUI);
            default: instr = utype_word(20'($random(seed)), rd, OPC_AUIPC);
         endcase
         ack_dly = $unsigned($random(seed)) % 6;
         rdy_dly = $unsigned($random(seed)) % 6;
         execute(instr, ack_dly, rdy_dly);
      end
   endtask

   initial begin
      seed       = 32'hea33;
      i_rst_n    = 1'b0;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_rf_ready = 1'b0;
      i_rdata0   = 1'b0;
      i_rdata1   = 1'b0;
      exp_pc     = RESET_PC;
      rf[0]      = '0;
      exp_rf[0]  = '0;
      load_random_regs();
      repeat (8) @(negedge clk);
      i_rst_n = 1'b1;
      test_reset();
      test_reg_ops();
      test_imm_ops();
      test_upper_imm();
      test_no_write();
      test_random_mix();
      $display("*** PASSED ***");
      $finish;
   end

endmodule
